// ==== source/ray_pkg.sv ====
package ray_pkg;

    ////////////////////////////////////////////////////////////
    // widths and fixed-point format

    localparam int X_W       = 11;
    localparam int Y_W       = 10;
    localparam int VEC_W     = 32;
    // unit direction components are Q16
    localparam int FRAC_BITS = 16;
    localparam int APB_AW    = 8;

    ////////////////////////////////////////////////////////////
    // register map in byte offsets

    localparam logic [APB_AW-1:0] ADDR_EYE_X     = 8'h00;
    localparam logic [APB_AW-1:0] ADDR_EYE_Y     = 8'h04;
    localparam logic [APB_AW-1:0] ADDR_EYE_Z     = 8'h08;
    localparam logic [APB_AW-1:0] ADDR_PLANE_X   = 8'h0C;
    localparam logic [APB_AW-1:0] ADDR_PLANE_Y   = 8'h10;
    localparam logic [APB_AW-1:0] ADDR_PLANE_Z   = 8'h14;
    // read only
    localparam logic [APB_AW-1:0] ADDR_RAY_COUNT = 8'h18;

    ////////////////////////////////////////////////////////////
    // default camera with the eye behind the projection plane

    localparam logic signed [VEC_W-1:0] RST_EYE_X   = 32'sd1800;
    localparam logic signed [VEC_W-1:0] RST_EYE_Y   = 32'sd1800;
    localparam logic signed [VEC_W-1:0] RST_EYE_Z   = -32'sd300;
    localparam logic signed [VEC_W-1:0] RST_PLANE_X = 32'sd1544;
    localparam logic signed [VEC_W-1:0] RST_PLANE_Y = 32'sd1608;
    localparam logic signed [VEC_W-1:0] RST_PLANE_Z = 32'sd100;

    // normalizer state encodings
    localparam int NORM_ST_W = 3;
    localparam logic [NORM_ST_W-1:0] NORM_IDLE     = 3'd0;
    localparam logic [NORM_ST_W-1:0] NORM_SUMSQ    = 3'd1;
    localparam logic [NORM_ST_W-1:0] NORM_SQRT     = 3'd2;
    localparam logic [NORM_ST_W-1:0] NORM_DIV_LOAD = 3'd3;
    localparam logic [NORM_ST_W-1:0] NORM_DIV      = 3'd4;
    localparam logic [NORM_ST_W-1:0] NORM_DONE     = 3'd5;

endpackage

// ==== source/ray_cfg_regs.sv ====
module ray_cfg_regs (
    input  logic                              clk_in,
    input  logic                              rst,
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic        [ray_pkg::APB_AW-1:0] paddr,
    input  logic        [ray_pkg::VEC_W-1:0]  pwdata,
    input  logic                              ray_done,
    output logic        [ray_pkg::VEC_W-1:0]  prdata,
    output logic                              pready,
    output logic                              pslverr,
    output logic signed [ray_pkg::VEC_W-1:0]  eye_x,
    output logic signed [ray_pkg::VEC_W-1:0]  eye_y,
    output logic signed [ray_pkg::VEC_W-1:0]  eye_z,
    output logic signed [ray_pkg::VEC_W-1:0]  plane_x,
    output logic signed [ray_pkg::VEC_W-1:0]  plane_y,
    output logic signed [ray_pkg::VEC_W-1:0]  plane_z
);
    import ray_pkg::*;

    logic             access;
    logic             mapped;
    logic             wr_en;
    logic [VEC_W-1:0] ray_count;

    // no wait states
    assign pready = 1'b1;
    assign access = psel && penable;

    // address decode and read data
    always_comb begin
        mapped = 1'b1;
        case (paddr)
            ADDR_EYE_X:     prdata = eye_x;
            ADDR_EYE_Y:     prdata = eye_y;
            ADDR_EYE_Z:     prdata = eye_z;
            ADDR_PLANE_X:   prdata = plane_x;
            ADDR_PLANE_Y:   prdata = plane_y;
            ADDR_PLANE_Z:   prdata = plane_z;
            ADDR_RAY_COUNT: prdata = ray_count;
            default: begin
                prdata = '0;
                mapped = 1'b0;
            end
        endcase
    end

    // unmapped address or a write to the counter
    assign pslverr = access && (!mapped || (pwrite && paddr == ADDR_RAY_COUNT));
    assign wr_en   = access && pwrite && !pslverr;

    always_ff @(posedge clk_in) begin
        if (rst) begin
            eye_x   <= RST_EYE_X;
            eye_y   <= RST_EYE_Y;
            eye_z   <= RST_EYE_Z;
            plane_x <= RST_PLANE_X;
            plane_y <= RST_PLANE_Y;
            plane_z <= RST_PLANE_Z;
        end else if (wr_en) begin
            case (paddr)
                ADDR_EYE_X:   eye_x   <= pwdata;
                ADDR_EYE_Y:   eye_y   <= pwdata;
                ADDR_EYE_Z:   eye_z   <= pwdata;
                ADDR_PLANE_X: plane_x <= pwdata;
                ADDR_PLANE_Y: plane_y <= pwdata;
                ADDR_PLANE_Z: plane_z <= pwdata;
                default: ;
            endcase
        end
    end

    // delivered rays wrap at 2^32
    always_ff @(posedge clk_in) begin
        if (rst) begin
            ray_count <= '0;
        end else if (ray_done) begin
            ray_count <= ray_count + 1'b1;
        end
    end

endmodule

// ==== source/pixel_to_plane.sv ====
module pixel_to_plane (
    input  logic                              clk_in,
    input  logic                              rst,
    input  logic                              pixel_valid,
    input  logic        [ray_pkg::X_W-1:0]    pixel_x,
    input  logic        [ray_pkg::Y_W-1:0]    pixel_y,
    input  logic signed [ray_pkg::VEC_W-1:0]  eye_x,
    input  logic signed [ray_pkg::VEC_W-1:0]  eye_y,
    input  logic signed [ray_pkg::VEC_W-1:0]  eye_z,
    input  logic signed [ray_pkg::VEC_W-1:0]  plane_x,
    input  logic signed [ray_pkg::VEC_W-1:0]  plane_y,
    input  logic signed [ray_pkg::VEC_W-1:0]  plane_z,
    input  logic                              dvec_ready,
    output logic                              pixel_ready,
    output logic                              dvec_valid,
    output logic signed [ray_pkg::VEC_W-1:0]  dvec_x,
    output logic signed [ray_pkg::VEC_W-1:0]  dvec_y,
    output logic signed [ray_pkg::VEC_W-1:0]  dvec_z
);
    import ray_pkg::*;

    logic                    s1_valid;
    logic signed [VEC_W-1:0] pt_x;
    logic signed [VEC_W-1:0] pt_y;
    logic signed [VEC_W-1:0] pt_z;
    logic signed [VEC_W-1:0] e_x;
    logic signed [VEC_W-1:0] e_y;
    logic signed [VEC_W-1:0] e_z;
    logic                    s1_adv;
    logic                    s2_adv;

    // a stage moves when the one after it is empty or draining
    assign s2_adv      = !dvec_valid || dvec_ready;
    assign s1_adv      = !s1_valid || s2_adv;
    assign pixel_ready = s1_adv;

    always_ff @(posedge clk_in) begin
        if (rst) begin
            s1_valid   <= 1'b0;
            dvec_valid <= 1'b0;
        end else begin
            if (s1_adv) begin
                s1_valid <= pixel_valid;
            end
            if (s2_adv) begin
                dvec_valid <= s1_valid;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // stage 1 forms the plane point with the eye snapshot alongside
    always_ff @(posedge clk_in) begin
        if (s1_adv && pixel_valid) begin
            pt_x <= plane_x + $signed({{(VEC_W-X_W){1'b0}}, pixel_x});
            pt_y <= plane_y + $signed({{(VEC_W-Y_W){1'b0}}, pixel_y});
            pt_z <= plane_z;
            e_x  <= eye_x;
            e_y  <= eye_y;
            e_z  <= eye_z;
        end
    end

    ////////////////////////////////////////////////////////////
    // stage 2 forms the direction from eye to plane point
    always_ff @(posedge clk_in) begin
        if (s2_adv && s1_valid) begin
            dvec_x <= pt_x - e_x;
            dvec_y <= pt_y - e_y;
            dvec_z <= pt_z - e_z;
        end
    end

endmodule

// ==== source/vec_normalize.sv ====
module vec_normalize (
    input  logic                              clk_in,
    input  logic                              rst,
    input  logic                              dvec_valid,
    input  logic signed [ray_pkg::VEC_W-1:0]  dvec_x,
    input  logic signed [ray_pkg::VEC_W-1:0]  dvec_y,
    input  logic signed [ray_pkg::VEC_W-1:0]  dvec_z,
    input  logic                              unit_ready,
    output logic                              dvec_ready,
    output logic                              unit_valid,
    output logic signed [ray_pkg::VEC_W-1:0]  unit_x,
    output logic signed [ray_pkg::VEC_W-1:0]  unit_y,
    output logic signed [ray_pkg::VEC_W-1:0]  unit_z
);
    import ray_pkg::*;

    logic [NORM_ST_W-1:0]    state;
    logic [VEC_W-1:0]        mag [3];
    logic [2:0]              neg;
    // radicand consumed two bits per step
    logic [VEC_W-1:0]        rad;
    // square root result that later serves as divisor
    logic [VEC_W-1:0]        root;
    // shared partial remainder for sqrt and divide
    logic [VEC_W-1:0]        rem;
    logic [VEC_W-1:0]        num;
    logic [VEC_W-1:0]        quo;
    logic [1:0]              comp;
    logic [4:0]              cnt;
    logic signed [VEC_W-1:0] unit_q [3];

    logic [VEC_W-1:0]        cur_mag;
    logic [VEC_W-1:0]        sq_rem;
    logic [VEC_W-1:0]        sq_trial;
    logic [VEC_W-1:0]        div_rem;
    logic                    div_ge;
    logic [VEC_W-1:0]        quo_next;

    assign dvec_ready = (state == NORM_IDLE);
    assign unit_valid = (state == NORM_DONE);
    assign unit_x     = unit_q[0];
    assign unit_y     = unit_q[1];
    assign unit_z     = unit_q[2];

    assign cur_mag  = mag[comp];

    // digit-by-digit square root step
    assign sq_rem   = {rem[VEC_W-3:0], rad[VEC_W-1 -: 2]};
    assign sq_trial = {root[VEC_W-3:0], 2'b01};

    // restoring divide step with one quotient bit per cycle
    assign div_rem  = {rem[VEC_W-2:0], num[FRAC_BITS]};
    assign div_ge   = (div_rem >= root);
    assign quo_next = {quo[VEC_W-2:0], div_ge};

    ////////////////////////////////////////////////////////////
    // control
    always_ff @(posedge clk_in) begin
        if (rst) begin
            state <= NORM_IDLE;
        end else begin
            case (state)
                NORM_IDLE: begin
                    if (dvec_valid) begin
                        state <= NORM_SUMSQ;
                    end
                end
                NORM_SUMSQ: state <= NORM_SQRT;
                NORM_SQRT: begin
                    // 16 steps for a 32-bit radicand
                    if (cnt == 5'(VEC_W / 2 - 1)) begin
                        state <= NORM_DIV_LOAD;
                    end
                end
                // zero length skips the divider
                NORM_DIV_LOAD: state <= (root == '0) ? NORM_DONE : NORM_DIV;
                NORM_DIV: begin
                    // quotient is at most 1.0 in Q16 and needs 17 bits
                    if (cnt == 5'(FRAC_BITS)) begin
                        state <= (comp == 2'd2) ? NORM_DONE : NORM_DIV_LOAD;
                    end
                end
                NORM_DONE: begin
                    if (unit_ready) begin
                        state <= NORM_IDLE;
                    end
                end
                default: state <= NORM_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // datapath
    always_ff @(posedge clk_in) begin
        case (state)
            NORM_IDLE: begin
                mag[0] <= dvec_x[VEC_W-1] ? -dvec_x : dvec_x;
                mag[1] <= dvec_y[VEC_W-1] ? -dvec_y : dvec_y;
                mag[2] <= dvec_z[VEC_W-1] ? -dvec_z : dvec_z;
                neg    <= {dvec_z[VEC_W-1], dvec_y[VEC_W-1], dvec_x[VEC_W-1]};
            end
            NORM_SUMSQ: begin
                // components within +-2^15 keep the sum inside 32 bits
                rad  <= mag[0] * mag[0] + mag[1] * mag[1] + mag[2] * mag[2];
                root <= '0;
                rem  <= '0;
                cnt  <= '0;
                comp <= '0;
            end
            NORM_SQRT: begin
                rad <= rad << 2;
                cnt <= cnt + 1'b1;
                if (sq_rem >= sq_trial) begin
                    rem  <= sq_rem - sq_trial;
                    root <= {root[VEC_W-2:0], 1'b1};
                end else begin
                    rem  <= sq_rem;
                    root <= {root[VEC_W-2:0], 1'b0};
                end
            end
            NORM_DIV_LOAD: begin
                num <= cur_mag << FRAC_BITS;
                // part of the dividend above the 17 quotient bits
                rem <= (cur_mag << FRAC_BITS) >> (FRAC_BITS + 1);
                quo <= '0;
                cnt <= '0;
                if (root == '0) begin
                    unit_q[0] <= '0;
                    unit_q[1] <= '0;
                    unit_q[2] <= '0;
                end
            end
            NORM_DIV: begin
                num <= num << 1;
                cnt <= cnt + 1'b1;
                quo <= quo_next;
                rem <= div_ge ? div_rem - root : div_rem;
                if (cnt == 5'(FRAC_BITS)) begin
                    unit_q[comp] <= neg[comp] ? -quo_next : quo_next;
                    comp         <= comp + 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

// ==== source/ray_out_buffer.sv ====
module ray_out_buffer (
    input  logic                              clk_in,
    input  logic                              rst,
    input  logic                              unit_valid,
    input  logic signed [ray_pkg::VEC_W-1:0]  unit_x,
    input  logic signed [ray_pkg::VEC_W-1:0]  unit_y,
    input  logic signed [ray_pkg::VEC_W-1:0]  unit_z,
    input  logic                              dir_ready,
    output logic                              unit_ready,
    output logic                              dir_valid,
    output logic signed [ray_pkg::VEC_W-1:0]  dir_x,
    output logic signed [ray_pkg::VEC_W-1:0]  dir_y,
    output logic signed [ray_pkg::VEC_W-1:0]  dir_z,
    output logic                              ray_done
);
    import ray_pkg::*;

    logic signed [VEC_W-1:0] fifo_x [2];
    logic signed [VEC_W-1:0] fifo_y [2];
    logic signed [VEC_W-1:0] fifo_z [2];
    logic                    wr_ptr;
    logic                    rd_ptr;
    logic [1:0]              count;
    logic                    push;
    logic                    pop;

    assign unit_ready = (count != 2'd2);
    assign dir_valid  = (count != 2'd0);
    assign push       = unit_valid && unit_ready;
    assign pop        = dir_valid && dir_ready;

    // head entry drives the output
    assign dir_x = fifo_x[rd_ptr];
    assign dir_y = fifo_y[rd_ptr];
    assign dir_z = fifo_z[rd_ptr];

    always_ff @(posedge clk_in) begin
        if (rst) begin
            wr_ptr   <= 1'b0;
            rd_ptr   <= 1'b0;
            count    <= 2'd0;
            ray_done <= 1'b0;
        end else begin
            wr_ptr   <= wr_ptr ^ push;
            rd_ptr   <= rd_ptr ^ pop;
            count    <= count + {1'b0, push} - {1'b0, pop};
            ray_done <= pop;
        end
    end

    always_ff @(posedge clk_in) begin
        if (push) begin
            fifo_x[wr_ptr] <= unit_x;
            fifo_y[wr_ptr] <= unit_y;
            fifo_z[wr_ptr] <= unit_z;
        end
    end

endmodule

// ==== source/eye_ray_gen.sv ====
module eye_ray_gen (
    input  logic                              clk_in,
    input  logic                              rst,
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic        [ray_pkg::APB_AW-1:0] paddr,
    input  logic        [ray_pkg::VEC_W-1:0]  pwdata,
    input  logic                              pixel_valid,
    input  logic        [ray_pkg::X_W-1:0]    pixel_x,
    input  logic        [ray_pkg::Y_W-1:0]    pixel_y,
    input  logic                              dir_ready,
    output logic        [ray_pkg::VEC_W-1:0]  prdata,
    output logic                              pready,
    output logic                              pslverr,
    output logic                              pixel_ready,
    output logic                              dir_valid,
    output logic signed [ray_pkg::VEC_W-1:0]  dir_x,
    output logic signed [ray_pkg::VEC_W-1:0]  dir_y,
    output logic signed [ray_pkg::VEC_W-1:0]  dir_z
);
    import ray_pkg::*;

    // camera configuration
    logic signed [VEC_W-1:0] eye_x, eye_y, eye_z;
    logic signed [VEC_W-1:0] plane_x, plane_y, plane_z;

    // raw direction and unit direction
    logic                    dvec_valid, dvec_ready;
    logic signed [VEC_W-1:0] dvec_x, dvec_y, dvec_z;
    logic                    unit_valid, unit_ready;
    logic signed [VEC_W-1:0] unit_x, unit_y, unit_z;
    logic                    ray_done;

    ray_cfg_regs cfg0 (
        .clk_in, .rst,
        .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
        .eye_x, .eye_y, .eye_z, .plane_x, .plane_y, .plane_z,
        .ray_done
    );

    pixel_to_plane p2p0 (
        .clk_in, .rst,
        .pixel_valid, .pixel_x, .pixel_y, .pixel_ready,
        .eye_x, .eye_y, .eye_z, .plane_x, .plane_y, .plane_z,
        .dvec_valid, .dvec_x, .dvec_y, .dvec_z, .dvec_ready
    );

    vec_normalize norm0 (
        .clk_in, .rst,
        .dvec_valid, .dvec_x, .dvec_y, .dvec_z, .dvec_ready,
        .unit_valid, .unit_x, .unit_y, .unit_z, .unit_ready
    );

    ray_out_buffer obuf0 (
        .clk_in, .rst,
        .unit_valid, .unit_x, .unit_y, .unit_z, .unit_ready,
        .dir_valid, .dir_x, .dir_y, .dir_z, .dir_ready,
        .ray_done
    );

endmodule

// ==== tests/eye_ray_gen_assert.sv ====
module eye_ray_gen_assert (
    input logic                             clk_in,
    input logic                             rst,
    input logic                             psel,
    input logic                             penable,
    input logic                             pslverr,
    input logic                             pixel_valid,
    input logic                             pixel_ready,
    input logic                             dir_valid,
    input logic                             dir_ready,
    input logic signed [ray_pkg::VEC_W-1:0] dir_x,
    input logic signed [ray_pkg::VEC_W-1:0] dir_y,
    input logic signed [ray_pkg::VEC_W-1:0] dir_z
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;

    // a pixel offer is not withdrawn
    pixel_hold: assert property (@(posedge clk_in) disable iff (rst)
        pixel_valid && !pixel_ready |=> pixel_valid)
        else begin
            fail_count++;
            $error("pixel_valid dropped before the pixel was accepted");
        end

    // stalled ray stays put
    dir_hold: assert property (@(posedge clk_in) disable iff (rst)
        dir_valid && !dir_ready |=>
            dir_valid && $stable(dir_x) && $stable(dir_y) && $stable(dir_z))
        else begin
            fail_count++;
            $error("ray output changed while stalled");
        end

    err_phase: assert property (@(posedge clk_in) disable iff (rst)
        pslverr |-> psel && penable)
        else begin
            fail_count++;
            $error("pslverr high outside an APB access phase");
        end

endmodule

bind eye_ray_gen eye_ray_gen_assert chk0 (
    .clk_in, .rst, .psel, .penable, .pslverr, .pixel_valid, .pixel_ready,
    .dir_valid, .dir_ready, .dir_x, .dir_y, .dir_z
);

// ==== tests/tb_eye_ray_gen.sv ====
module tb_eye_ray_gen;
    timeunit 1ns;
    timeprecision 1ps;
    import ray_pkg::*;

    typedef struct packed {
        logic [X_W-1:0] x;
        logic [Y_W-1:0] y;
        logic           rnd;
    } row_t;

    localparam int N_ROWS = 14;
    // rows from here on run with the reprogrammed camera
    localparam int N_DEF  = 8;
    // pixel x, pixel y, random dir_ready
    localparam row_t ROWS [N_ROWS] = '{
        '{11'd0, 10'd0, 1'b0},    '{11'd511, 10'd0, 1'b0},
        '{11'd0, 10'd383, 1'b0},  '{11'd511, 10'd383, 1'b0},
        '{11'd256, 10'd192, 1'b0}, '{11'd100, 10'd300, 1'b1},
        '{11'd2047, 10'd1023, 1'b1}, '{11'd37, 10'd250, 1'b1},
        '{11'd50, 10'd60, 1'b0},  '{11'd0, 10'd0, 1'b1},
        '{11'd511, 10'd383, 1'b1}, '{11'd50, 10'd61, 1'b1},
        '{11'd300, 10'd10, 1'b1}, '{11'd7, 10'd7, 1'b1}
    };

    logic                    clk_in = 1'b0;
    logic                    rst, psel, penable, pwrite, pready, pslverr;
    logic [APB_AW-1:0]       paddr;
    logic [VEC_W-1:0]        pwdata, prdata;
    logic                    pixel_valid, pixel_ready, dir_valid, dir_ready;
    logic [X_W-1:0]          pixel_x;
    logic [Y_W-1:0]          pixel_y;
    logic signed [VEC_W-1:0] dir_x, dir_y, dir_z;

    int         errors = 0;
    bit         rnd_mode = 1'b0;
    int         m_eye [3] = '{RST_EYE_X, RST_EYE_Y, RST_EYE_Z};
    int         m_plane [3] = '{RST_PLANE_X, RST_PLANE_Y, RST_PLANE_Z};
    int         exp_x [$];
    int         exp_y [$];
    int         exp_z [$];
    int         ex, ey, ez;
    logic [31:0] rd;
    logic       err;

    eye_ray_gen dut0 (.*);

    always #5 clk_in = ~clk_in;

    ////////////////////////////////////////////////////////////
    // reference model

    function automatic longint int_sqrt(input longint s);
        longint lo, hi, mid;
        lo = 0;
        hi = 65536;
        while (lo < hi) begin
            mid = (lo + hi + 1) / 2;
            if (mid * mid <= s)
                lo = mid;
            else
                hi = mid - 1;
        end
        return lo;
    endfunction

    task automatic expect_ray(input int x, input int y);
        longint d [3];
        longint len;
        int     u [3];
        d[0] = longint'(m_plane[0]) + x - m_eye[0];
        d[1] = longint'(m_plane[1]) + y - m_eye[1];
        d[2] = longint'(m_plane[2]) - m_eye[2];
        len  = int_sqrt(d[0] * d[0] + d[1] * d[1] + d[2] * d[2]);
        // Q16 with division truncating toward zero
        for (int k = 0; k < 3; k++) begin
            u[k] = (len == 0) ? 0 : int'((d[k] * 65536) / len);
        end
        exp_x.push_back(u[0]);
        exp_y.push_back(u[1]);
        exp_z.push_back(u[2]);
    endtask

    task automatic check_value(input string name, input int got, input int want);
        assert (got == want) else begin
            errors++;
            $display("error at %0t: %s is %0d, expected %0d", $time, name, got, want);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // bus and pixel drivers

    task automatic apb_access(input logic wr, input logic [APB_AW-1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic slverr);
        @(negedge clk_in);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk_in);
        penable = 1'b1;
        @(posedge clk_in);
        // zero wait states, every access takes two cycles
        check_value("pready", pready, 1);
        while (!pready) @(posedge clk_in);
        rdata  = prdata;
        slverr = pslverr;
        @(negedge clk_in);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic check_reg(input string name, input logic [APB_AW-1:0] addr, input int want);
        logic [31:0] data;
        logic        slverr;
        apb_access(1'b0, addr, 32'd0, data, slverr);
        check_value(name, data, want);
        check_value("pslverr", slverr, 0);
    endtask

    task automatic program_camera(input int e [3], input int p [3]);
        logic [APB_AW-1:0] addr [6] = '{ADDR_EYE_X, ADDR_EYE_Y, ADDR_EYE_Z,
                                        ADDR_PLANE_X, ADDR_PLANE_Y, ADDR_PLANE_Z};
        logic [31:0]       data;
        logic              slverr;
        for (int k = 0; k < 6; k++) begin
            apb_access(1'b1, addr[k], (k < 3) ? e[k] : p[k-3], data, slverr);
            check_value("pslverr", slverr, 0);
        end
        m_eye   = e;
        m_plane = p;
    endtask

    task automatic send_pixel(input row_t r);
        @(negedge clk_in);
        rnd_mode    <= r.rnd;
        pixel_valid = 1'b1;
        pixel_x     = r.x;
        pixel_y     = r.y;
        @(posedge clk_in);
        while (!pixel_ready) @(posedge clk_in);
        expect_ray(r.x, r.y);
    endtask

    task automatic wait_drained();
        @(negedge clk_in);
        pixel_valid = 1'b0;
        while (exp_x.size() != 0) @(posedge clk_in);
        // ray_done is registered so the counter lags one cycle
        repeat (2) @(posedge clk_in);
    endtask

    // output back-pressure
    initial begin
        void'($urandom(32'h74f7_25e3));
        dir_ready = 1'b0;
        forever begin
            @(negedge clk_in);
            dir_ready = rnd_mode ? 1'($urandom & 32'd1) : 1'b1;
        end
    end

    // compare every delivered ray with the model in order
    always @(posedge clk_in) begin
        if (!rst && dir_valid && dir_ready) begin
            if (exp_x.size() == 0) begin
                errors++;
                $display("ray delivered at %0t with no pixel pending", $time);
            end else begin
                ex = exp_x.pop_front();
                ey = exp_y.pop_front();
                ez = exp_z.pop_front();
                check_value("dir_x", dir_x, ex);
                check_value("dir_y", dir_y, ey);
                check_value("dir_z", dir_z, ez);
            end
        end
    end

    initial begin
        repeat (N_ROWS * 200 + 2000) @(posedge clk_in);
        $display("timeout, %0d rays still pending", exp_x.size());
        $display("Test failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // main sequence

    initial begin
        rst         = 1'b1;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        pixel_valid = 1'b0;
        pixel_x     = '0;
        pixel_y     = '0;
        repeat (5) @(posedge clk_in);
        @(negedge clk_in);
        rst = 1'b0;
        check_value("pixel_ready", pixel_ready, 1);
        check_value("dir_valid", dir_valid, 0);

        check_reg("eye_x", ADDR_EYE_X, RST_EYE_X);
        check_reg("eye_y", ADDR_EYE_Y, RST_EYE_Y);
        check_reg("eye_z", ADDR_EYE_Z, RST_EYE_Z);
        check_reg("plane_x", ADDR_PLANE_X, RST_PLANE_X);
        check_reg("plane_y", ADDR_PLANE_Y, RST_PLANE_Y);
        check_reg("plane_z", ADDR_PLANE_Z, RST_PLANE_Z);
        check_reg("ray_count", ADDR_RAY_COUNT, 0);

        for (int i = 0; i < N_ROWS; i++) begin
            if (i == N_DEF) begin
                wait_drained();
                // eye lands on the plane point of pixel (50, 60)
                program_camera('{-50, 260, 50}, '{-100, 200, 50});
            end
            send_pixel(ROWS[i]);
        end
        wait_drained();

        check_reg("ray_count", ADDR_RAY_COUNT, N_ROWS);
        apb_access(1'b0, 8'h1C, 32'd0, rd, err);
        check_value("pslverr", err, 1);
        apb_access(1'b1, ADDR_RAY_COUNT, 32'h0000_5a5a, rd, err);
        check_value("pslverr", err, 1);
        check_reg("ray_count", ADDR_RAY_COUNT, N_ROWS);

        $display("errors: %0d checks, %0d assertions", errors, dut0.chk0.fail_count);
        if (errors == 0 && dut0.chk0.fail_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
source/ray_pkg.sv
source/ray_cfg_regs.sv
source/pixel_to_plane.sv
source/vec_normalize.sv
source/ray_out_buffer.sv
source/eye_ray_gen.sv
tests/eye_ray_gen_assert.sv
tests/tb_eye_ray_gen.sv

// ==== run.sh ====
#!/bin/sh
# build and run the eye ray generator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module tb_eye_ray_gen -o sim_eye_ray_gen
./obj_dir/sim_eye_ray_gen +verilator+error+limit+100 > sim.log 2>&1
cat sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
exit 0
